/* maze_game.f */
+incdir+common
common/maze_pkg.sv
hw/game_state_fsm.sv
hw/game_logic/game_logic.sv
hw/frame_render.sv
hw/maze_game_top.sv
verification/maze_game_checker.sv
verification/maze_game_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= maze_game_tb
FILELIST  ?= maze_game.f
BUILD_DIR ?= build
LOG       ?= $(BUILD_DIR)/sim.log
DEFINES   ?=
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  := sim failed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run, search $(LOG) for the fail message"
	@echo "  clean  remove $(BUILD_DIR)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG DEFINES VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) $(DEFINES) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "FAILED"; exit 1; \
	fi; \
	echo "PASSED"

clean:
	rm -rf $(BUILD_DIR)

/* verification/maze_game_tb.sv */
`timescale 1ns/1ps
`include "maze_defs.svh"
`default_nettype none

module maze_game_tb import maze_pkg::*; ();

    localparam int NUM_ROWS = 14;
    localparam int CLK_HALF = 2;
    localparam int WATCHDOG_CYCLES = (NUM_ROWS + 2) * (`FRAME_TICKS + 600);

    // Key for each frame and the controller state once that frame is drawn
    localparam logic [7:0] KEY_TAB [NUM_ROWS] = '{
        8'h1D, 8'h1C, 8'h55, 8'h23, 8'h23, 8'h1C, 8'h23,
        8'h1B, 8'h1B, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00
    };
    localparam game_state_t STATE_TAB [NUM_ROWS] = '{
        WAITING, WAITING, WAITING, WAITING, WAITING, WAITING, WAITING,
        WAITING, WAITING, WAITING, WAITING, WAITING, WAITING, GAME_OVER
    };

    logic        clock;
    logic        resetn;
    logic        start_key;
    logic [7:0]  key_code;
    logic        vga_ready;
    logic [4:0]  vga_x;
    logic [3:0]  vga_y;
    logic [11:0] vga_color;
    logic        vga_valid;
    logic [7:0]  score;
    game_state_t game_state;

    // Reference game state
    int px;
    int py;
    int gx [3];
    int gy [3];
    bit food [`GRID_CELLS];
    int exp_score;
    bit lost;
    bit won;

    int errors;
    int checks;
    int stretch;

    maze_game_top dut0 (
        .clock      (clock),
        .resetn     (resetn),
        .start_key  (start_key),
        .key_code   (key_code),
        .vga_ready  (vga_ready),
        .vga_x      (vga_x),
        .vga_y      (vga_y),
        .vga_color  (vga_color),
        .vga_valid  (vga_valid),
        .score      (score),
        .game_state (game_state)
    );

    initial begin
        clock = 1'b0;
        forever #CLK_HALF clock = ~clock;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("sim failed");
        $finish;
    end

    task automatic check_state(input game_state_t got, input game_state_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] game_state got %h expected %h", got, exp);
        end
    endtask

    task automatic check_pixel(input logic [4:0] got_x, input logic [3:0] got_y,
                               input logic [11:0] got_c, input logic [4:0] exp_x,
                               input logic [3:0] exp_y, input logic [11:0] exp_c);
        checks++;
        if (got_x !== exp_x || got_y !== exp_y) begin
            errors++;
            $display("[FAIL] vga_x/vga_y got %h/%h expected %h/%h", got_x, got_y, exp_x, exp_y);
        end else if (got_c !== exp_c) begin
            errors++;
            $display("[FAIL] vga_color at %h/%h got %h expected %h", exp_x, exp_y, got_c, exp_c);
        end
    endtask

    task automatic check_score(input logic [7:0] got, input logic [7:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] score got %h expected %h", got, exp);
        end
    endtask

    task automatic model_reset();
        for (int i = 0; i < `GRID_CELLS; i++) begin
            food[i] = (((i % `GRID_W) + (i / `GRID_W)) % 2) == 0;
        end
        food[`PLAYER_Y0 * `GRID_W + `PLAYER_X0] = 1'b0;
        px = `PLAYER_X0;
        py = `PLAYER_Y0;
        gx[0] = `GHOST0_X;
        gy[0] = `GHOST0_Y;
        gx[1] = `GHOST1_X;
        gy[1] = `GHOST1_Y;
        gx[2] = `GHOST2_X;
        gy[2] = `GHOST2_Y;
        exp_score = 0;
        lost = 1'b0;
        won = 1'b0;
    endtask

    // One game step: move, ghosts, eat, then judge
    task automatic model_step(input logic [7:0] key);
        int idx;
        case (key)
            8'h1D: if (py > 0) py--;
            8'h1B: if (py < `GRID_H - 1) py++;
            8'h1C: if (px > 0) px--;
            8'h23: if (px < `GRID_W - 1) px++;
            default: ;
        endcase
        for (int g = 0; g < 3; g++) begin
            gx[g] = (gx[g] + 1) % `GRID_W;
        end
        idx = py * `GRID_W + px;
        if (food[idx]) begin
            food[idx] = 1'b0;
            exp_score++;
        end
        for (int g = 0; g < 3; g++) begin
            if (gx[g] == px && gy[g] == py) lost = 1'b1;
        end
        if (!lost && exp_score == `FOOD_TOTAL) won = 1'b1;
    endtask

    function automatic logic [11:0] model_color(input int x, input int y);
        for (int g = 0; g < 3; g++) begin
            if (gx[g] == x && gy[g] == y) return COLOR_GHOST;
        end
        if (px == x && py == y) return COLOR_PLAYER;
        if (food[y * `GRID_W + x]) return COLOR_FOOD;
        return COLOR_EMPTY;
    endfunction

    // Random stretches of back-pressure
    task automatic drive_ready();
        if (stretch == 0) begin
            vga_ready = (($urandom % 4) != 0);
            stretch = 1 + int'($urandom % 6);
        end
        stretch--;
    endtask

    // Take 512 pixels; ready for the next edge is set first, then the offer is read
    task automatic collect_frame(input bit solid, input logic [11:0] fill);
        int n;
        logic [11:0] exp_c;
        n = 0;
        while (n < `GRID_CELLS) begin
            @(negedge clock);
            drive_ready();
            if (vga_valid && vga_ready) begin
                exp_c = solid ? fill : model_color(n % `GRID_W, n / `GRID_W);
                check_pixel(vga_x, vga_y, vga_color, 5'(n % `GRID_W), 4'(n / `GRID_W), exp_c);
                n++;
            end
        end
        // render_done, then the controller moves on
        @(negedge clock);
        @(negedge clock);
    endtask

    task automatic expect_silence(input int cycles);
        repeat (cycles) begin
            @(negedge clock);
            drive_ready();
            checks++;
            if (vga_valid) begin
                errors++;
                $display("Pixel offered at %h/%h while the stream should be idle", vga_x, vga_y);
            end
        end
    endtask

    initial begin
        int row_errors;
        void'($urandom(17178));
        errors = 0;
        checks = 0;
        stretch = 0;
        resetn = 1'b0;
        start_key = 1'b0;
        key_code = 8'h00;
        vga_ready = 1'b0;
        model_reset();
        repeat (4) @(negedge clock);
        resetn = 1'b1;

        // Greeting screen stays dark until the start key
        expect_silence(20);
        check_state(game_state, GREETING);
        check_score(score, 8'h00);
        key_code = KEY_TAB[0];
        start_key = 1'b1;
        @(negedge clock);
        start_key = 1'b0;
        collect_frame(1'b1, COLOR_GREETING);
        $display("greeting frame: %0d errors", errors);

        for (int r = 0; r < NUM_ROWS; r++) begin
            row_errors = errors;
            model_step(KEY_TAB[r]);
            if (lost) begin
                collect_frame(1'b1, COLOR_LOST);
            end else if (won) begin
                collect_frame(1'b1, COLOR_WON);
            end else begin
                collect_frame(1'b0, COLOR_EMPTY);
            end
            check_state(game_state, STATE_TAB[r]);
            check_score(score, 8'(exp_score));
            if (r + 1 < NUM_ROWS) key_code = KEY_TAB[r + 1];
            $display("row %0d key %h player %0d/%0d score %0d: %0d errors",
                     r, KEY_TAB[r], px, py, exp_score, errors - row_errors);
        end

        // Final screen is drawn once only
        expect_silence(`FRAME_TICKS);
        check_state(game_state, STATE_TAB[NUM_ROWS - 1]);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verification/maze_game_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module maze_game_checker import maze_pkg::*; (
    input logic        clock,
    input logic        resetn,
    input logic        vga_valid,
    input logic        vga_ready,
    input logic [4:0]  vga_x,
    input logic [3:0]  vga_y,
    input logic [11:0] vga_color,
    input logic        logic_start,
    input logic        logic_done,
    input logic        render_start,
    input game_state_t game_state
);

    // Stalled pixel holds position and colour
    a_pixel_hold: assert property (@(posedge clock) disable iff (!resetn)
        vga_valid && !vga_ready |=> vga_valid && $stable(vga_x) && $stable(vga_y)
            && $stable(vga_color))
        else $error("pixel changed while the plotter stalled");

    // Stages start one at a time, logic answers after two cycles, render follows
    a_stage_order: assert property (@(posedge clock) disable iff (!resetn)
        logic_start |-> !render_start ##2 logic_done ##1 render_start)
        else $error("stage sequence broken after logic_start");

    a_quiet_wait: assert property (@(posedge clock) disable iff (!resetn)
        game_state == WAITING |-> !vga_valid)
        else $error("vga_valid high while waiting for the frame tick");

endmodule

bind maze_game_top maze_game_checker chk0 (
    .clock        (clock),
    .resetn       (resetn),
    .vga_valid    (vga_valid),
    .vga_ready    (vga_ready),
    .vga_x        (vga_x),
    .vga_y        (vga_y),
    .vga_color    (vga_color),
    .logic_start  (logic_start),
    .logic_done   (logic_done),
    .render_start (render_start),
    .game_state   (game_state)
);

`default_nettype wire

/* hw/maze_game_top.sv */
`timescale 1ns/1ps
`include "maze_defs.svh"
`default_nettype none

module maze_game_top import maze_pkg::*; (
    input  logic        clock,
    input  logic        resetn,
    input  logic        start_key,
    input  logic [7:0]  key_code,
    input  logic        vga_ready,
    output logic [4:0]  vga_x,
    output logic [3:0]  vga_y,
    output logic [11:0] vga_color,
    output logic        vga_valid,
    output logic [7:0]  score,
    output game_state_t game_state
);

    // Stage handshakes
    logic         logic_start;
    logic         logic_done;
    logic         collided;
    logic         all_eaten;
    logic         render_start;
    logic         render_done;
    screen_mode_t screen_mode;

    // Game state seen by the renderer
    logic [4:0]             player_x;
    logic [3:0]             player_y;
    logic [4:0]             ghost0_x;
    logic [3:0]             ghost0_y;
    logic [4:0]             ghost1_x;
    logic [3:0]             ghost1_y;
    logic [4:0]             ghost2_x;
    logic [3:0]             ghost2_y;
    logic [`GRID_CELLS-1:0] food_map;

    game_state_fsm u_fsm (
        .clock        (clock),
        .resetn       (resetn),
        .start_key    (start_key),
        .logic_done   (logic_done),
        .collided     (collided),
        .all_eaten    (all_eaten),
        .render_done  (render_done),
        .logic_start  (logic_start),
        .render_start (render_start),
        .screen_mode  (screen_mode),
        .game_state   (game_state)
    );

    game_logic u_logic (
        .clock       (clock),
        .resetn      (resetn),
        .logic_start (logic_start),
        .key_code    (key_code),
        .logic_done  (logic_done),
        .collided    (collided),
        .all_eaten   (all_eaten),
        .player_x    (player_x),
        .player_y    (player_y),
        .ghost0_x    (ghost0_x),
        .ghost0_y    (ghost0_y),
        .ghost1_x    (ghost1_x),
        .ghost1_y    (ghost1_y),
        .ghost2_x    (ghost2_x),
        .ghost2_y    (ghost2_y),
        .food_map    (food_map),
        .score       (score)
    );

    frame_render u_render (
        .clock        (clock),
        .resetn       (resetn),
        .render_start (render_start),
        .screen_mode  (screen_mode),
        .player_x     (player_x),
        .player_y     (player_y),
        .ghost0_x     (ghost0_x),
        .ghost0_y     (ghost0_y),
        .ghost1_x     (ghost1_x),
        .ghost1_y     (ghost1_y),
        .ghost2_x     (ghost2_x),
        .ghost2_y     (ghost2_y),
        .food_map     (food_map),
        .vga_ready    (vga_ready),
        .render_done  (render_done),
        .vga_x        (vga_x),
        .vga_y        (vga_y),
        .vga_color    (vga_color),
        .vga_valid    (vga_valid)
    );

endmodule

`default_nettype wire

/* hw/frame_render.sv */
`timescale 1ns/1ps
`include "maze_defs.svh"
`default_nettype none

module frame_render import maze_pkg::*; (
    input  logic                   clock,
    input  logic                   resetn,
    input  logic                   render_start,
    input  screen_mode_t           screen_mode,
    input  logic [4:0]             player_x,
    input  logic [3:0]             player_y,
    input  logic [4:0]             ghost0_x,
    input  logic [3:0]             ghost0_y,
    input  logic [4:0]             ghost1_x,
    input  logic [3:0]             ghost1_y,
    input  logic [4:0]             ghost2_x,
    input  logic [3:0]             ghost2_y,
    input  logic [`GRID_CELLS-1:0] food_map,
    input  logic                   vga_ready,
    output logic                   render_done,
    output logic [4:0]             vga_x,
    output logic [3:0]             vga_y,
    output logic [11:0]            vga_color,
    output logic                   vga_valid
);

    localparam int IDX_W = $clog2(`GRID_CELLS);

    logic [IDX_W-1:0] cell_idx;
    logic             last_cell;
    logic             accept;
    cell_kind_t       cell_kind;

    assign cell_idx  = IDX_W'(vga_y) * IDX_W'(`GRID_W) + IDX_W'(vga_x);
    assign last_cell = (vga_x == 5'(`GRID_W - 1)) && (vga_y == 4'(`GRID_H - 1));
    assign accept    = vga_valid && vga_ready;

    // Ghosts are drawn over the player, the player over food
    always_comb begin
        if ((vga_x == ghost0_x && vga_y == ghost0_y) ||
            (vga_x == ghost1_x && vga_y == ghost1_y) ||
            (vga_x == ghost2_x && vga_y == ghost2_y)) begin
            cell_kind = CELL_GHOST;
        end else if (vga_x == player_x && vga_y == player_y) begin
            cell_kind = CELL_PLAYER;
        end else if (food_map[cell_idx]) begin
            cell_kind = CELL_FOOD;
        end else begin
            cell_kind = CELL_EMPTY;
        end
    end

    always_comb begin
        case (screen_mode)
            SCREEN_PLAY: begin
                case (cell_kind)
                    CELL_GHOST:  vga_color = COLOR_GHOST;
                    CELL_PLAYER: vga_color = COLOR_PLAYER;
                    CELL_FOOD:   vga_color = COLOR_FOOD;
                    default:     vga_color = COLOR_EMPTY;
                endcase
            end
            SCREEN_LOST: vga_color = COLOR_LOST;
            SCREEN_WON:  vga_color = COLOR_WON;
            default:     vga_color = COLOR_GREETING;
        endcase
    end

    // Row-major scan, x fastest, one step per accepted pixel
    always_ff @(posedge clock or negedge resetn) begin
        if (!resetn) begin
            vga_x       <= 5'd0;
            vga_y       <= 4'd0;
            vga_valid   <= 1'b0;
            render_done <= 1'b0;
        end else begin
            render_done <= 1'b0;
            if (render_start) begin
                vga_x     <= 5'd0;
                vga_y     <= 4'd0;
                vga_valid <= 1'b1;
            end else if (accept) begin
                if (last_cell) begin
                    vga_valid   <= 1'b0;
                    render_done <= 1'b1;
                end else if (vga_x == 5'(`GRID_W - 1)) begin
                    vga_x <= 5'd0;
                    vga_y <= vga_y + 4'd1;
                end else begin
                    vga_x <= vga_x + 5'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hw/game_logic/game_logic.sv */
`timescale 1ns/1ps
`include "maze_defs.svh"
`default_nettype none

module game_logic import maze_pkg::*; (
    input  logic                   clock,
    input  logic                   resetn,
    input  logic                   logic_start,
    input  logic [7:0]             key_code,
    output logic                   logic_done,
    output logic                   collided,
    output logic                   all_eaten,
    output logic [4:0]             player_x,
    output logic [3:0]             player_y,
    output logic [4:0]             ghost0_x,
    output logic [3:0]             ghost0_y,
    output logic [4:0]             ghost1_x,
    output logic [3:0]             ghost1_y,
    output logic [4:0]             ghost2_x,
    output logic [3:0]             ghost2_y,
    output logic [`GRID_CELLS-1:0] food_map,
    output logic [7:0]             score
);

    localparam int IDX_W = $clog2(`GRID_CELLS);

    // Pellet on every even x + y cell except the player start
    function automatic logic [`GRID_CELLS-1:0] food_init();
        logic [`GRID_CELLS-1:0] map;
        map = '0;
        for (int y = 0; y < `GRID_H; y++) begin
            for (int x = 0; x < `GRID_W; x++) begin
                if (((x + y) % 2) == 0) begin
                    map[y * `GRID_W + x] = 1'b1;
                end
            end
        end
        map[`PLAYER_Y0 * `GRID_W + `PLAYER_X0] = 1'b0;
        return map;
    endfunction

    localparam logic [`GRID_CELLS-1:0] FOOD_INIT = food_init();

    // Ghosts run right and wrap at the edge
    function automatic logic [4:0] ghost_step(input logic [4:0] gx);
        return (gx == 5'(`GRID_W - 1)) ? 5'd0 : gx + 5'd1;
    endfunction

    move_op_t         move_op;
    logic [4:0]       next_x;
    logic [3:0]       next_y;
    logic             step2;
    logic [IDX_W-1:0] cell_idx;
    logic [7:0]       score_next;
    logic             hit;

    always_comb begin
        case (key_code)
            KEY_W:   move_op = MOVE_UP;
            KEY_S:   move_op = MOVE_DOWN;
            KEY_A:   move_op = MOVE_LEFT;
            KEY_D:   move_op = MOVE_RIGHT;
            default: move_op = MOVE_NONE;
        endcase
    end

    // New player cell, clamped at the borders
    always_comb begin
        next_x = player_x;
        next_y = player_y;
        case (move_op)
            MOVE_UP:    if (player_y != 4'd0) next_y = player_y - 4'd1;
            MOVE_DOWN:  if (player_y != 4'(`GRID_H - 1)) next_y = player_y + 4'd1;
            MOVE_LEFT:  if (player_x != 5'd0) next_x = player_x - 5'd1;
            MOVE_RIGHT: if (player_x != 5'(`GRID_W - 1)) next_x = player_x + 5'd1;
            default:    next_x = player_x;
        endcase
    end

    assign cell_idx   = IDX_W'(player_y) * IDX_W'(`GRID_W) + IDX_W'(player_x);
    assign score_next = score + {7'd0, food_map[cell_idx]};
    assign hit = (player_x == ghost0_x && player_y == ghost0_y) ||
                 (player_x == ghost1_x && player_y == ghost1_y) ||
                 (player_x == ghost2_x && player_y == ghost2_y);

    // Ghost rows never change
    assign ghost0_y = 4'(`GHOST0_Y);
    assign ghost1_y = 4'(`GHOST1_Y);
    assign ghost2_y = 4'(`GHOST2_Y);

    always_ff @(posedge clock or negedge resetn) begin
        if (!resetn) begin
            player_x   <= 5'(`PLAYER_X0);
            player_y   <= 4'(`PLAYER_Y0);
            ghost0_x   <= 5'(`GHOST0_X);
            ghost1_x   <= 5'(`GHOST1_X);
            ghost2_x   <= 5'(`GHOST2_X);
            food_map   <= FOOD_INIT;
            score      <= 8'd0;
            step2      <= 1'b0;
            logic_done <= 1'b0;
            collided   <= 1'b0;
            all_eaten  <= 1'b0;
        end else begin
            step2      <= logic_start;
            logic_done <= step2;
            // First cycle moves everybody
            if (logic_start) begin
                player_x <= next_x;
                player_y <= next_y;
                ghost0_x <= ghost_step(ghost0_x);
                ghost1_x <= ghost_step(ghost1_x);
                ghost2_x <= ghost_step(ghost2_x);
            end
            // Second cycle eats and judges
            if (step2) begin
                food_map[cell_idx] <= 1'b0;
                score              <= score_next;
                collided           <= hit;
                all_eaten          <= (score_next == 8'(`FOOD_TOTAL));
            end
        end
    end

endmodule

`default_nettype wire

/* hw/game_state_fsm.sv */
`timescale 1ns/1ps
`include "maze_defs.svh"
`default_nettype none

module game_state_fsm import maze_pkg::*; (
    input  logic         clock,
    input  logic         resetn,
    input  logic         start_key,
    input  logic         logic_done,
    input  logic         collided,
    input  logic         all_eaten,
    input  logic         render_done,
    output logic         logic_start,
    output logic         render_start,
    output screen_mode_t screen_mode,
    output game_state_t  game_state
);

    localparam int TICK_W = $clog2(`FRAME_TICKS + 1);
    localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(`FRAME_TICKS - 1);

    // Cycles since the last logic_start, saturating
    logic [TICK_W-1:0] tick_cnt;
    // Greeting frame is being drawn
    logic              greet_busy;

    always_ff @(posedge clock or negedge resetn) begin
        if (!resetn) begin
            game_state   <= GREETING;
            screen_mode  <= SCREEN_GREETING;
            logic_start  <= 1'b0;
            render_start <= 1'b0;
            greet_busy   <= 1'b0;
            tick_cnt     <= '0;
        end else begin
            logic_start  <= 1'b0;
            render_start <= 1'b0;
            if (tick_cnt != TICK_LAST) begin
                tick_cnt <= tick_cnt + 1'b1;
            end
            case (game_state)
                GREETING: begin
                    if (!greet_busy && start_key) begin
                        greet_busy   <= 1'b1;
                        render_start <= 1'b1;
                        screen_mode  <= SCREEN_GREETING;
                    end else if (greet_busy && render_done) begin
                        greet_busy  <= 1'b0;
                        game_state  <= LOGIC;
                        logic_start <= 1'b1;
                        tick_cnt    <= '0;
                    end
                end
                LOGIC: begin
                    if (logic_done) begin
                        render_start <= 1'b1;
                        // Collision wins over an empty food map
                        if (collided) begin
                            game_state  <= GAME_OVER;
                            screen_mode <= SCREEN_LOST;
                        end else if (all_eaten) begin
                            game_state  <= YOU_WON;
                            screen_mode <= SCREEN_WON;
                        end else begin
                            game_state  <= RENDER;
                            screen_mode <= SCREEN_PLAY;
                        end
                    end
                end
                RENDER: begin
                    if (render_done) begin
                        game_state <= WAITING;
                    end
                end
                WAITING: begin
                    if (tick_cnt == TICK_LAST) begin
                        game_state  <= LOGIC;
                        logic_start <= 1'b1;
                        tick_cnt    <= '0;
                    end
                end
                GAME_OVER, YOU_WON: begin
                    // Final frame already requested, hold until reset
                end
                default: begin
                    game_state <= GREETING;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* common/maze_pkg.sv */
`default_nettype none

package maze_pkg;

    // Controller states
    typedef enum logic [2:0] {
        GREETING,
        LOGIC,
        RENDER,
        WAITING,
        GAME_OVER,
        YOU_WON
    } game_state_t;

    // Player move decoded from the key
    typedef enum logic [2:0] {
        MOVE_NONE,
        MOVE_UP,
        MOVE_DOWN,
        MOVE_LEFT,
        MOVE_RIGHT
    } move_op_t;

    // Picture the renderer produces
    typedef enum logic [1:0] {
        SCREEN_GREETING,
        SCREEN_PLAY,
        SCREEN_LOST,
        SCREEN_WON
    } screen_mode_t;

    // Topmost occupant of a cell
    typedef enum logic [1:0] {
        CELL_EMPTY,
        CELL_FOOD,
        CELL_PLAYER,
        CELL_GHOST
    } cell_kind_t;

    // Scan codes of W, S, A, D
    localparam logic [7:0] KEY_W = 8'h1D;
    localparam logic [7:0] KEY_S = 8'h1B;
    localparam logic [7:0] KEY_A = 8'h1C;
    localparam logic [7:0] KEY_D = 8'h23;

    // 12-bit RGB colours
    localparam logic [11:0] COLOR_EMPTY    = 12'h000;
    localparam logic [11:0] COLOR_FOOD     = 12'hFFF;
    localparam logic [11:0] COLOR_PLAYER   = 12'hFF0;
    localparam logic [11:0] COLOR_GHOST    = 12'hF00;
    localparam logic [11:0] COLOR_GREETING = 12'h00F;
    localparam logic [11:0] COLOR_LOST     = 12'hF00;
    localparam logic [11:0] COLOR_WON      = 12'h0F0;

endpackage

`default_nettype wire

/* common/maze_defs.svh */
`ifndef MAZE_DEFS_SVH
`define MAZE_DEFS_SVH
`default_nettype none

// Playfield size in cells
`define GRID_W 32
`define GRID_H 16
`define GRID_CELLS (`GRID_W * `GRID_H)

// Player start cell
`define PLAYER_X0 0
`define PLAYER_Y0 0

// Ghost start cells, one per row band
`define GHOST0_X 20
`define GHOST0_Y 2
`define GHOST1_X 10
`define GHOST1_Y 8
`define GHOST2_X 5
`define GHOST2_Y 13

// Even x + y cells, less the player start cell when it is one of them
`define FOOD_TOTAL (((`GRID_W * `GRID_H) + 1) / 2 - ((`PLAYER_X0 + `PLAYER_Y0 + 1) % 2))

// Clock cycles from one logic step to the next
`define FRAME_TICKS 1024

`default_nettype wire
`endif
